// ==== Makefile ====
# Verilator flow for the WISC memory stage

VERILATOR ?= verilator
TOP       ?= tb_memory_stage
RTL_TOP   ?= memory_stage
FLIST     ?= src.f
BUILD_DIR ?= obj_dir
LINT_OPTS ?= --timing
SIM_OPTS  ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_OPTS) -f $(FLIST) --top-module $(RTL_TOP)

# The run's exit status is the pass/fail result
sim:
	$(VERILATOR) --binary $(SIM_OPTS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== source/data_cache.sv ====
//////////////////////////////////////////////////
// Direct-mapped write-through data cache
// Backing memory plus the miss and store sequencer
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "wisc_macros.svh"

module data_cache (
   input  logic     clk,
   input  logic     rst,
   mem_req_if.cache req
);

   localparam int IDX_W = $clog2(`CACHE_LINES);
   localparam int MEM_AW = $clog2(`MEM_WORDS);
   localparam int CNT_W = $clog2(`MISS_CYCLES + 1);

   mem_pkg::tag_line_t      lines [`CACHE_LINES];
   logic [`WORD_W-1:0]      mem [`MEM_WORDS];

   mem_pkg::cache_state_e   state_q;
   mem_pkg::cache_state_e   state_d;
   logic [CNT_W-1:0]        cnt_q;
   logic [CNT_W-1:0]        cnt_d;

   logic [IDX_W-1:0]        idx;
   logic [`WORD_W-5:0]      tag;
   logic [MEM_AW-1:0]       widx;
   logic                    hit;
   logic                    fill;
   logic                    wr_commit;

   //////////////////////////////////////////////////
   // Address split and lookup
   //////////////////////////////////////////////////

   // Bit 0 is the byte within the word
   assign idx  = req.addr[IDX_W:1];
   assign tag  = req.addr[`WORD_W-1:IDX_W+1];
   assign widx = req.addr[MEM_AW:1];

   assign hit = lines[idx].valid && (lines[idx].tag == tag);

   //////////////////////////////////////////////////
   // Sequencer
   //////////////////////////////////////////////////

   always_comb begin
      req.done  = 1'b0;
      req.busy  = 1'b0;
      req.err   = 1'b0;
      req.rdata = lines[idx].data;
      state_d   = state_q;
      cnt_d     = cnt_q;
      fill      = 1'b0;
      wr_commit = 1'b0;
      unique case (state_q)
         mem_pkg::IDLE: begin
            if (req.rd || req.wr) begin
               if (req.addr[0]) begin
                  // Odd address, no access at all
                  req.err  = 1'b1;
                  req.done = 1'b1;
               end else if (req.rd && hit) begin
                  req.done = 1'b1;
               end else begin
                  // Miss or store, busy from this cycle on
                  req.busy = 1'b1;
                  cnt_d    = CNT_W'(`MISS_CYCLES - 1);
                  state_d  = req.rd ? mem_pkg::RD_MISS : mem_pkg::WR_THRU;
               end
            end
         end
         mem_pkg::RD_MISS: begin
            req.rdata = mem[widx];
            if (cnt_q == '0) begin
               req.done = 1'b1;
               fill     = 1'b1;
               state_d  = mem_pkg::IDLE;
            end else begin
               req.busy = 1'b1;
               cnt_d    = cnt_q - 1'b1;
            end
         end
         mem_pkg::WR_THRU: begin
            if (cnt_q == '0) begin
               req.done  = 1'b1;
               wr_commit = 1'b1;
               state_d   = mem_pkg::IDLE;
            end else begin
               req.busy = 1'b1;
               cnt_d    = cnt_q - 1'b1;
            end
         end
         default: state_d = mem_pkg::IDLE;
      endcase
   end

   //////////////////////////////////////////////////
   // State, lines and backing memory
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= mem_pkg::IDLE;
         cnt_q   <= '0;
         for (int i = 0; i < `CACHE_LINES; i++) begin
            lines[i].valid <= 1'b0;
         end
         // Word i starts out as 3*i
         for (int i = 0; i < `MEM_WORDS; i++) begin
            mem[i] <= `WORD_W'(i * 3);
         end
      end else begin
         state_q <= state_d;
         cnt_q   <= cnt_d;
         if (fill) begin
            lines[idx].valid <= 1'b1;
            lines[idx].tag   <= tag;
            lines[idx].data  <= mem[widx];
         end
         if (wr_commit) begin
            mem[widx] <= req.wdata;
            // No allocate on a write miss
            if (hit)
               lines[idx].data <= req.wdata;
         end
      end
   end

   // Reply only to a live request
   a_done_req: assert property (@(posedge clk) disable iff (rst)
      req.done |-> (req.rd || req.wr));

   // Busy drops by the last cycle of the slow access
   a_busy_len: assert property (@(posedge clk) disable iff (rst)
      $rose(req.busy) |-> ##(`MISS_CYCLES) !req.busy);

endmodule

`default_nettype wire

// ==== source/isa_pkg.sv ====
//////////////////////////////////////////////////
// WISC instruction set definitions
// Opcodes, the two instruction word layouts and
// the writeback source select
//////////////////////////////////////////////////

package isa_pkg;

   //////////////////////////////////////////////////
   // Opcodes (upper five bits of the word)
   //////////////////////////////////////////////////

   localparam logic [4:0] OP_ST   = 5'b10000;
   localparam logic [4:0] OP_LD   = 5'b10001;
   localparam logic [4:0] OP_STU  = 5'b10011;
   localparam logic [4:0] OP_JAL  = 5'b00110;
   localparam logic [4:0] OP_LBI  = 5'b11000;
   // Shared by all register-register ALU ops
   localparam logic [4:0] OP_RFMT = 5'b11011;

   // Register-register layout
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] func;
   } r_fmt_t;

   // Register-immediate layout
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [4:0] imm;
   } i_fmt_t;

   // Same 16 bits, two decodings
   typedef union packed {
      r_fmt_t r_fmt;
      i_fmt_t i_fmt;
   } instr_u;

   // Where writeback data comes from
   typedef enum logic [1:0] {
      WB_ALU = 2'b00,
      WB_MEM = 2'b01,
      WB_PC  = 2'b10
   } wb_sel_e;

endpackage

// ==== source/mem_decode.sv ====
//////////////////////////////////////////////////
// Memory stage decoder
// Turns the opcode into cache strobes, picks the
// destination register and writeback source
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "wisc_macros.svh"

module mem_decode (
   input  logic                 clk,
   input  isa_pkg::instr_u      instruction,
   input  logic [`WORD_W-1:0]   address,
   input  logic [`WORD_W-1:0]   write_data,
   mem_req_if.requester         req,
   output logic                 stall,
   output logic [2:0]           dest_rd,
   output isa_pkg::wb_sel_e     wb_sel
);

   logic [4:0] opcode;

   assign opcode = instruction.r_fmt.opcode;

   //////////////////////////////////////////////////
   // Cache strobes
   //////////////////////////////////////////////////

   // Only LD reads
   assign req.rd = (opcode == isa_pkg::OP_LD);
   // ST and STU: top bits 100, low two bits equal
   assign req.wr = (opcode[4:2] == 3'b100) & ~^opcode[1:0];

   // Address and store data straight from execute
   // rt value passes through unforwarded
   assign req.addr  = address;
   assign req.wdata = write_data;

   // Busy alone stalls, done releases the same cycle
   assign stall = req.busy & ~req.done;

   //////////////////////////////////////////////////
   // Destination register and writeback source
   //////////////////////////////////////////////////

   always_comb begin
      unique case (opcode)
         isa_pkg::OP_RFMT: dest_rd = instruction.r_fmt.rd;
         // STU and LBI write the register in bits 10:8
         isa_pkg::OP_STU,
         isa_pkg::OP_LBI:  dest_rd = instruction.i_fmt.rs;
         // Link register
         isa_pkg::OP_JAL:  dest_rd = 3'd7;
         default:          dest_rd = instruction.i_fmt.rd;
      endcase
   end

   always_comb begin
      if (opcode == isa_pkg::OP_LD)
         wb_sel = isa_pkg::WB_MEM;
      else if (opcode == isa_pkg::OP_JAL)
         wb_sel = isa_pkg::WB_PC;
      else
         wb_sel = isa_pkg::WB_ALU;
   end

   // One access kind per instruction on the bus
   a_rd_wr_excl: assert property (@(posedge clk) !(req.rd && req.wr));

endmodule

`default_nettype wire

// ==== source/mem_pkg.sv ====
//////////////////////////////////////////////////
// Data cache types
// Line bookkeeping and controller states
//////////////////////////////////////////////////

`include "wisc_macros.svh"

package mem_pkg;

   // One cache line
   // Tag is the address above index and byte bits
   typedef struct packed {
      logic                 valid;
      logic [`WORD_W-5:0]   tag;
      logic [`WORD_W-1:0]   data;
   } tag_line_t;

   //////////////////////////////////////////////////
   // Controller states
   //////////////////////////////////////////////////

   typedef enum logic [1:0] {
      // Waiting for a request, hits served here
      IDLE    = 2'b00,
      // Counting down a line fill
      RD_MISS = 2'b01,
      // Counting down a store to backing memory
      WR_THRU = 2'b10
   } cache_state_e;

endpackage

// ==== source/mem_req_if.sv ====
//////////////////////////////////////////////////
// Memory request bus
// Level-held read/write request from the decoder
// and the cache reply
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "wisc_macros.svh"

interface mem_req_if;

   // Request side, held until done
   logic               rd;
   logic               wr;
   logic [`WORD_W-1:0] addr;
   logic [`WORD_W-1:0] wdata;

   // Reply side
   logic [`WORD_W-1:0] rdata;
   logic               done;
   logic               busy;
   // Unaligned access, reported with done
   logic               err;

   modport requester (
      output rd, wr, addr, wdata,
      input  rdata, done, busy, err
   );

   modport cache (
      input  rd, wr, addr, wdata,
      output rdata, done, busy, err
   );

endinterface

`default_nettype wire

// ==== source/mem_wb_regs.sv ====
//////////////////////////////////////////////////
// MEM/WB pipeline register
// Frozen during a stall, selects writeback data
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "wisc_macros.svh"

module mem_wb_regs (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 stall,
   input  logic [`WORD_W-1:0]   instruction,
   input  logic [`WORD_W-1:0]   incr_pc,
   input  logic [`WORD_W-1:0]   alu_result,
   input  logic [`WORD_W-1:0]   rdata,
   input  logic                 reg_wrt,
   input  logic                 err_in,
   input  logic [2:0]           dest_rd,
   input  isa_pkg::wb_sel_e     wb_sel,
   output logic [`WORD_W-1:0]   instruction_out,
   output logic [`WORD_W-1:0]   wb_data,
   output logic [2:0]           wb_rd,
   output logic                 reg_wrt_out,
   output logic                 err_out
);

   logic [`WORD_W-1:0]  pc_q;
   logic [`WORD_W-1:0]  alu_q;
   logic [`WORD_W-1:0]  rdata_q;
   isa_pkg::wb_sel_e    wb_sel_q;

   // Control bits
   always_ff @(posedge clk) begin
      if (rst) begin
         reg_wrt_out <= 1'b0;
         err_out     <= 1'b0;
         wb_sel_q    <= isa_pkg::WB_ALU;
      end else if (!stall) begin
         reg_wrt_out <= reg_wrt;
         err_out     <= err_in;
         wb_sel_q    <= wb_sel;
      end
   end

   // Payload fields
   always_ff @(posedge clk) begin
      if (!stall) begin
         instruction_out <= instruction;
         pc_q            <= incr_pc;
         alu_q           <= alu_result;
         rdata_q         <= rdata;
         wb_rd           <= dest_rd;
      end
   end

   //////////////////////////////////////////////////
   // Writeback data select
   //////////////////////////////////////////////////

   always_comb begin
      unique case (wb_sel_q)
         isa_pkg::WB_MEM: wb_data = rdata_q;
         isa_pkg::WB_PC:  wb_data = pc_q;
         default:         wb_data = alu_q;
      endcase
   end

   // Stall freezes everything seen by writeback
   a_hold: assert property (@(posedge clk) disable iff (rst)
      stall |=> $stable(instruction_out) && $stable(wb_data) && $stable(wb_rd)
                && $stable(reg_wrt_out) && $stable(err_out));

endmodule

`default_nettype wire

// ==== source/memory_stage.sv ====
//////////////////////////////////////////////////
// WISC memory stage
// Decoder, data cache and MEM/WB register
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "wisc_macros.svh"

module memory_stage (
   input  wire                  clk,
   input  wire                  rst,
   input  wire [`WORD_W-1:0]    instruction,
   input  wire [`WORD_W-1:0]    address,
   input  wire [`WORD_W-1:0]    write_data,
   input  wire [`WORD_W-1:0]    incr_pc,
   input  wire [`WORD_W-1:0]    alu_result,
   input  wire                  reg_wrt,
   input  wire                  unaligned_in,
   output wire                  stall,
   output wire [`WORD_W-1:0]    instruction_out,
   output wire [`WORD_W-1:0]    wb_data,
   output wire [2:0]            wb_rd,
   output wire                  reg_wrt_out,
   output wire                  err_out
);

   wire [2:0]           dest_rd;
   isa_pkg::wb_sel_e    wb_sel;

   mem_req_if req_bus ();

   // Execute error or cache alignment error
   wire err_any = unaligned_in | req_bus.err;

   mem_decode u_decode (
      .clk         (clk),
      .instruction (instruction),
      .address     (address),
      .write_data  (write_data),
      .req         (req_bus.requester),
      .stall       (stall),
      .dest_rd     (dest_rd),
      .wb_sel      (wb_sel)
   );

   data_cache u_cache (
      .clk (clk),
      .rst (rst),
      .req (req_bus.cache)
   );

   mem_wb_regs u_mem_wb (
      .clk             (clk),
      .rst             (rst),
      .stall           (stall),
      .instruction     (instruction),
      .incr_pc         (incr_pc),
      .alu_result      (alu_result),
      .rdata           (req_bus.rdata),
      .reg_wrt         (reg_wrt),
      .err_in          (err_any),
      .dest_rd         (dest_rd),
      .wb_sel          (wb_sel),
      .instruction_out (instruction_out),
      .wb_data         (wb_data),
      .wb_rd           (wb_rd),
      .reg_wrt_out     (reg_wrt_out),
      .err_out         (err_out)
   );

endmodule

`default_nettype wire

// ==== source/wisc_macros.svh ====
//////////////////////////////////////////////////
// WISC memory stage build constants
// Word width, cache geometry, backing memory size
// and the miss latency of the slow memory
//////////////////////////////////////////////////

`ifndef WISC_MACROS_SVH
`define WISC_MACROS_SVH

// Data and address width
`define WORD_W 16

// One-word lines, direct mapped
`define CACHE_LINES 8

// Backing memory depth in words
`define MEM_WORDS 256

// Backing memory access time in cycles
// Also the length of every write-through
`define MISS_CYCLES 4

`endif

// ==== src.f ====
+incdir+source
source/isa_pkg.sv
source/mem_pkg.sv
source/mem_req_if.sv
source/mem_decode.sv
source/data_cache.sv
source/mem_wb_regs.sv
source/memory_stage.sv
tests/tb_memory_stage.sv

// ==== tests/tb_memory_stage.sv ====
//////////////////////////////////////////////////
// Memory stage testbench
// Table of instructions against a cache model
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "wisc_macros.svh"

module tb_memory_stage;

   localparam int NROWS = 24;
   localparam int M     = `MISS_CYCLES;
   localparam int LIMIT = NROWS * (`MISS_CYCLES + 2) + 50;

   localparam logic [4:0] LD  = isa_pkg::OP_LD;
   localparam logic [4:0] ST  = isa_pkg::OP_ST;
   localparam logic [4:0] STU = isa_pkg::OP_STU;
   localparam logic [4:0] JAL = isa_pkg::OP_JAL;
   localparam logic [4:0] LBI = isa_pkg::OP_LBI;

   typedef struct {
      logic [15:0] instr;
      logic [15:0] addr;
      logic [15:0] wdata;
      logic        wrt;
      logic        unal;
      int          slow;
   } row_t;

   logic        clk = 1'b0;
   logic        rst;
   logic [15:0] instruction, address, write_data, incr_pc, alu_result;
   logic        reg_wrt, unaligned_in;
   wire         stall, reg_wrt_out, err_out;
   wire  [15:0] instruction_out, wb_data;
   wire  [2:0]  wb_rd;

   row_t        rows [NROWS];
   logic [15:0] alu_v [NROWS];
   logic [15:0] pc_v [NROWS];
   int          cycles = 0;

   // Reference model of backing memory and lines
   logic [15:0] m_mem [256];
   logic        m_valid [8];
   logic [11:0] m_tag [8];
   logic [15:0] m_data [8];

   // Expected results of the current row
   logic [15:0] exp_data;
   logic [2:0]  exp_rd;
   logic        exp_err, data_known;
   int          exp_stall;

   // Output snapshot for the stall hold check
   logic [15:0] hold_instr, hold_data;
   logic [2:0]  hold_rd;
   logic        hold_wrt, hold_err;

   memory_stage dut0 (
      .clk(clk), .rst(rst), .instruction(instruction), .address(address),
      .write_data(write_data), .incr_pc(incr_pc), .alu_result(alu_result),
      .reg_wrt(reg_wrt), .unaligned_in(unaligned_in), .stall(stall),
      .instruction_out(instruction_out), .wb_data(wb_data), .wb_rd(wb_rd),
      .reg_wrt_out(reg_wrt_out), .err_out(err_out)
   );

   always #20 clk = ~clk;

   // Run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > LIMIT) begin
         $display("=== FAIL ===");
         $fatal(1, "Timeout: the run went past %0d cycles", LIMIT);
      end
   end

   function automatic logic [15:0] imm_instr(logic [4:0] op, int rs, int rd, int imm);
      return {op, 3'(rs), 3'(rd), 5'(imm)};
   endfunction

   function automatic logic [15:0] reg_instr(int rs, int rt, int rd, int fn);
      return {isa_pkg::OP_RFMT, 3'(rs), 3'(rt), 3'(rd), 2'(fn)};
   endfunction

   task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
         $display("=== FAIL ===");
         $fatal(1, "Value mismatch on %s", name);
      end
   endtask

   task automatic apply_row(input int i);
      instruction  <= rows[i].instr;
      address      <= rows[i].addr;
      write_data   <= rows[i].wdata;
      reg_wrt      <= rows[i].wrt;
      unaligned_in <= rows[i].unal;
      alu_result   <= alu_v[i];
      incr_pc      <= pc_v[i];
   endtask

   task automatic apply_idle();
      instruction  <= 16'h0000;
      address      <= 16'h0000;
      reg_wrt      <= 1'b0;
      unaligned_in <= 1'b0;
   endtask

   task automatic take_snapshot();
      hold_instr = instruction_out;
      hold_data  = wb_data;
      hold_rd    = wb_rd;
      hold_wrt   = reg_wrt_out;
      hold_err   = err_out;
   endtask

   // Expected outputs of one row, model updated as the cache would be
   task automatic predict(input int i);
      logic [4:0]  op;
      logic [7:0]  w;
      logic [2:0]  ix;
      logic [11:0] tg;
      logic        is_ld, is_st, hit;
      op    = rows[i].instr[15:11];
      w     = rows[i].addr[8:1];
      ix    = rows[i].addr[3:1];
      tg    = rows[i].addr[15:4];
      is_ld = (op == LD);
      is_st = (op == ST) || (op == STU);
      hit   = m_valid[ix] && (m_tag[ix] == tg);
      exp_err    = rows[i].unal || ((is_ld || is_st) && rows[i].addr[0]);
      exp_stall  = 0;
      exp_data   = (op == JAL) ? pc_v[i] : alu_v[i];
      data_known = 1'b1;
      if (op == isa_pkg::OP_RFMT)
         exp_rd = rows[i].instr[4:2];
      else if (op == STU || op == LBI)
         exp_rd = rows[i].instr[10:8];
      else if (op == JAL)
         exp_rd = 3'd7;
      else
         exp_rd = rows[i].instr[7:5];
      if ((is_ld || is_st) && rows[i].addr[0]) begin
         // Odd address, read data undefined
         data_known = !is_ld;
      end else if (is_ld) begin
         if (!hit) begin
            exp_stall   = M;
            m_valid[ix] = 1'b1;
            m_tag[ix]   = tg;
            m_data[ix]  = m_mem[w];
         end
         exp_data = m_data[ix];
      end else if (is_st) begin
         exp_stall = M;
         m_mem[w]  = rows[i].wdata;
         if (hit)
            m_data[ix] = rows[i].wdata;
      end
   endtask

   initial begin
      int n_stall;
      void'($urandom(3167));
      // Opcode fields, address, store data, reg_wrt, unaligned_in, stall cycles
      rows[0]  = '{imm_instr(LD, 0, 1, 0),  16'h0010, 16'h0000, 1'b1, 1'b0, M};
      rows[1]  = '{imm_instr(LD, 0, 2, 0),  16'h0010, 16'h0000, 1'b1, 1'b0, 0};
      rows[2]  = '{imm_instr(ST, 0, 1, 0),  16'h0010, 16'hbeef, 1'b0, 1'b0, M};
      rows[3]  = '{imm_instr(LD, 0, 3, 0),  16'h0010, 16'h0000, 1'b1, 1'b0, 0};
      // Store miss, no allocate
      rows[4]  = '{imm_instr(ST, 0, 2, 0),  16'h0024, 16'h1234, 1'b0, 1'b0, M};
      rows[5]  = '{imm_instr(LD, 0, 4, 0),  16'h0024, 16'h0000, 1'b1, 1'b0, M};
      // Same index, alternating evictions
      rows[6]  = '{imm_instr(LD, 0, 5, 0),  16'h0030, 16'h0000, 1'b1, 1'b0, M};
      rows[7]  = '{imm_instr(LD, 0, 6, 0),  16'h0010, 16'h0000, 1'b1, 1'b0, M};
      rows[8]  = '{imm_instr(LD, 0, 7, 0),  16'h0030, 16'h0000, 1'b1, 1'b0, M};
      rows[9]  = '{imm_instr(LD, 0, 1, 0),  16'h0010, 16'h0000, 1'b1, 1'b0, M};
      // Alignment errors
      rows[10] = '{imm_instr(LD, 0, 2, 0),  16'h0011, 16'h0000, 1'b1, 1'b0, 0};
      rows[11] = '{imm_instr(ST, 0, 2, 0),  16'h0023, 16'h7777, 1'b0, 1'b0, 0};
      rows[12] = '{reg_instr(1, 2, 5, 0),   16'h0000, 16'h0000, 1'b1, 1'b1, 0};
      rows[13] = '{reg_instr(3, 1, 4, 1),   16'h0000, 16'h0000, 1'b1, 1'b0, 0};
      rows[14] = '{imm_instr(STU, 6, 2, 0), 16'h0040, 16'h5555, 1'b1, 1'b0, M};
      rows[15] = '{imm_instr(LD, 0, 3, 0),  16'h0040, 16'h0000, 1'b1, 1'b0, M};
      rows[16] = '{imm_instr(LBI, 3, 0, 9), 16'h0000, 16'h0000, 1'b1, 1'b0, 0};
      rows[17] = '{imm_instr(JAL, 0, 0, 4), 16'h0000, 16'h0000, 1'b1, 1'b0, 0};
      rows[18] = '{imm_instr(LD, 0, 4, 0),  16'h0040, 16'h0000, 1'b1, 1'b0, 0};
      rows[19] = '{imm_instr(LD, 0, 5, 0),  16'h01fe, 16'h0000, 1'b1, 1'b0, M};
      // Store hit updates the line
      rows[20] = '{imm_instr(ST, 0, 1, 0),  16'h0040, 16'ha5a5, 1'b0, 1'b0, M};
      rows[21] = '{imm_instr(LD, 0, 6, 0),  16'h0040, 16'h0000, 1'b1, 1'b0, 0};
      rows[22] = '{reg_instr(4, 5, 1, 2),   16'h0000, 16'h0000, 1'b1, 1'b0, 0};
      rows[23] = '{imm_instr(LD, 0, 7, 0),  16'h0002, 16'h0000, 1'b1, 1'b0, M};
      for (int i = 0; i < NROWS; i++) begin
         alu_v[i] = 16'($urandom);
         pc_v[i]  = 16'($urandom);
      end
      for (int i = 0; i < 256; i++) begin
         m_mem[i] = 16'(i * 3);
      end
      for (int i = 0; i < 8; i++) begin
         m_valid[i] = 1'b0;
      end

      rst = 1'b1;
      write_data = 16'h0000;
      incr_pc = 16'h0000;
      alu_result = 16'h0000;
      instruction = 16'h0000;
      address = 16'h0000;
      // Flags held high so only reset clears the registered copies
      reg_wrt = 1'b1;
      unaligned_in = 1'b1;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      apply_idle();
      @(negedge clk);
      check("stall", 16'(stall), 16'h0000);
      check("reg_wrt_out", 16'(reg_wrt_out), 16'h0000);
      check("err_out", 16'(err_out), 16'h0000);
      take_snapshot();

      @(posedge clk);
      apply_row(0);
      @(negedge clk);
      for (int i = 0; i < NROWS; i++) begin
         n_stall = 0;
         // Outputs frozen while the cache works
         while (stall) begin
            n_stall++;
            check("instruction_out", instruction_out, hold_instr);
            check("wb_data", wb_data, hold_data);
            check("wb_rd", 16'(wb_rd), 16'(hold_rd));
            check("reg_wrt_out", 16'(reg_wrt_out), 16'(hold_wrt));
            check("err_out", 16'(err_out), 16'(hold_err));
            @(negedge clk);
         end
         predict(i);
         check($sformatf("row %0d stall cycles", i), 16'(n_stall), 16'(exp_stall));
         check($sformatf("row %0d table stall", i), 16'(exp_stall), 16'(rows[i].slow));
         @(posedge clk);
         if (i + 1 < NROWS)
            apply_row(i + 1);
         else
            apply_idle();
         @(negedge clk);
         check($sformatf("row %0d instruction_out", i), instruction_out, rows[i].instr);
         check($sformatf("row %0d wb_rd", i), 16'(wb_rd), 16'(exp_rd));
         check($sformatf("row %0d err_out", i), 16'(err_out), 16'(exp_err));
         check($sformatf("row %0d reg_wrt_out", i), 16'(reg_wrt_out), 16'(rows[i].wrt));
         if (data_known)
            check($sformatf("row %0d wb_data", i), wb_data, exp_data);
         take_snapshot();
      end

      $display("=== PASS ===");
      $finish;
   end

endmodule
